//--- common/muldiv_defs.svh
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// Operand and result width
`define MULDIV_XLEN 64

// Multiplier slice, the signed slice element is one bit wider
`define MULDIV_SLICE 16

// Divider iterations, one quotient bit each
`define MULDIV_ITER_D 64
`define MULDIV_ITER_W 32

`endif

//--- common/muldiv_pkg.sv
`include "muldiv_defs.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_XLEN-1:0] word_t;

    // M-extension funct3, bit 2 selects the divider
    typedef logic [2:0] funct3_t;

    // Two signed slice products plus headroom for a column of four
    typedef logic signed [2*(`MULDIV_SLICE+1)+2:0] accum_t;

    typedef struct packed {
        funct3_t op;
        logic    is_word;
        word_t   operand_a;
        word_t   operand_b;
    } muldiv_req_t;

    typedef enum logic {
        IDLE,
        BUSY
    } mul_state_e;

endpackage

//--- muldiv/mul_unit.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module mul_unit (
    input  logic              clk,
    input  logic              rstn,
    input  muldiv_pkg::word_t i_operand_a,
    input  muldiv_pkg::word_t i_operand_b,
    input  logic [1:0]        i_op,
    input  logic              i_word,
    input  logic              i_valid,
    output logic              o_ready,
    output muldiv_pkg::word_t o_value,
    output logic              o_valid
);

    muldiv_pkg::mul_state_e state, state_d;

    logic [1:0] a_idx, a_idx_d;
    logic [1:0] b_idx, b_idx_d;
    logic [2:0] col;
    logic [2:0] col_next;
    logic       col_end;
    logic       done;

    // Operands with one extension bit, sign or zero
    logic [`MULDIV_XLEN:0] op_a, op_a_d;
    logic [`MULDIV_XLEN:0] op_b, op_b_d;
    logic                  op_low, op_low_d;
    logic                  op_word, op_word_d;

    muldiv_pkg::accum_t            accum, accum_d;
    muldiv_pkg::accum_t            mac_prod;
    logic signed [`MULDIV_SLICE:0] mac_a;
    logic signed [`MULDIV_SLICE:0] mac_b;

    muldiv_pkg::word_t value_d;
    logic              valid_d;

    // Lower slices are unsigned, only the top one carries the sign
    function automatic logic [`MULDIV_SLICE:0] slice_of(
        input logic [`MULDIV_XLEN:0] op,
        input logic [1:0]            idx
    );
        logic [`MULDIV_SLICE:0] s;
        if (idx == 2'd3) begin
            s = op[`MULDIV_XLEN:3*`MULDIV_SLICE];
        end else begin
            s = {1'b0, op[idx*`MULDIV_SLICE +: `MULDIV_SLICE]};
        end
        return s;
    endfunction

    assign o_ready = (state == muldiv_pkg::IDLE);

    // The single multiply-accumulate
    assign mac_a    = slice_of(op_a, a_idx);
    assign mac_b    = slice_of(op_b, b_idx);
    assign mac_prod = accum + mac_a * mac_b;

    // Column walk runs from the highest a slice down
    assign col      = {1'b0, a_idx} + {1'b0, b_idx};
    assign col_next = col + 3'd1;
    assign col_end  = (a_idx == 2'd0) || (b_idx == 2'd3);
    assign done     = (col == 3'd1 && op_word) || (col == 3'd3 && op_low) || (col == 3'd6);

    always_comb begin
        state_d   = state;
        a_idx_d   = a_idx;
        b_idx_d   = b_idx;
        op_a_d    = op_a;
        op_b_d    = op_b;
        op_low_d  = op_low;
        op_word_d = op_word;
        accum_d   = accum;
        value_d   = o_value;
        valid_d   = 1'b0;

        case (state)
            muldiv_pkg::IDLE: begin
                if (i_valid) begin
                    // Only MULHU treats a as unsigned, MULHSU and MULHU treat b so
                    op_a_d    = {(i_op != 2'b11) & i_operand_a[`MULDIV_XLEN-1], i_operand_a};
                    op_b_d    = {~i_op[1] & i_operand_b[`MULDIV_XLEN-1], i_operand_b};
                    op_low_d  = (i_op == 2'b00);
                    op_word_d = i_word;
                    accum_d   = '0;
                    a_idx_d   = 2'd0;
                    b_idx_d   = 2'd0;
                    state_d   = muldiv_pkg::BUSY;
                end
            end
            muldiv_pkg::BUSY: begin
                accum_d = mac_prod;
                if (!col_end) begin
                    a_idx_d = a_idx - 2'd1;
                    b_idx_d = b_idx + 2'd1;
                end else begin
                    // High columns 4 to 6 reuse the low result slots
                    value_d[col[1:0]*`MULDIV_SLICE +: `MULDIV_SLICE] =
                        mac_prod[`MULDIV_SLICE-1:0];
                    accum_d = mac_prod >>> `MULDIV_SLICE;

                    if (col_next > 3'd3) begin
                        a_idx_d = 2'd3;
                        b_idx_d = col_next[1:0] + 2'd1;
                    end else begin
                        a_idx_d = col_next[1:0];
                        b_idx_d = 2'd0;
                    end

                    if (col == 3'd1 && op_word) begin
                        value_d[`MULDIV_XLEN-1:`MULDIV_SLICE] =
                            {{(`MULDIV_XLEN-2*`MULDIV_SLICE){mac_prod[`MULDIV_SLICE-1]}},
                             mac_prod[`MULDIV_SLICE-1:0]};
                    end
                    if (col == 3'd6) begin
                        // Last column holds the top 32 bits with all carries in
                        value_d[`MULDIV_XLEN-1:2*`MULDIV_SLICE] =
                            mac_prod[2*`MULDIV_SLICE-1:0];
                    end

                    if (done) begin
                        valid_d = 1'b1;
                        state_d = muldiv_pkg::IDLE;
                    end
                end
            end
            default: begin
                state_d = muldiv_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= muldiv_pkg::IDLE;
            a_idx   <= 2'd0;
            b_idx   <= 2'd0;
            o_valid <= 1'b0;
        end else begin
            state   <= state_d;
            a_idx   <= a_idx_d;
            b_idx   <= b_idx_d;
            o_valid <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        op_a    <= op_a_d;
        op_b    <= op_b_d;
        op_low  <= op_low_d;
        op_word <= op_word_d;
        accum   <= accum_d;
        o_value <= value_d;
    end

endmodule

//--- muldiv/div_unit.sv
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module div_unit (
    input  logic              clk,
    input  logic              rstn,
    input  muldiv_pkg::word_t i_operand_a,
    input  muldiv_pkg::word_t i_operand_b,
    input  logic              i_rem,
    input  logic              i_unsigned,
    input  logic              i_word,
    input  logic              i_valid,
    output logic              o_ready,
    output muldiv_pkg::word_t o_value,
    output logic              o_valid
);

    typedef logic [$clog2(`MULDIV_ITER_D):0] iter_t;

    muldiv_pkg::word_t a_ext;
    muldiv_pkg::word_t b_ext;
    logic              a_sign;
    logic              b_sign;
    muldiv_pkg::word_t a_mag;
    muldiv_pkg::word_t b_mag;
    muldiv_pkg::word_t a_flip;
    muldiv_pkg::word_t a_rev;

    // Iterations left, zero means idle
    iter_t             iter, iter_d;
    muldiv_pkg::word_t dvd, dvd_d;
    muldiv_pkg::word_t dsr, dsr_d;
    muldiv_pkg::word_t quo, quo_d;
    muldiv_pkg::word_t rem, rem_d;
    logic              quo_neg, quo_neg_d;
    logic              rem_neg, rem_neg_d;
    logic              use_rem, use_rem_d;
    logic              is_word, is_word_d;

    muldiv_pkg::word_t value_d;
    logic              valid_d;

    assign o_ready = (iter == '0);

    // Sign and magnitude, word operands extended first
    always_comb begin
        if (i_word) begin
            a_ext = {{(`MULDIV_XLEN-`MULDIV_ITER_W){~i_unsigned & i_operand_a[`MULDIV_ITER_W-1]}},
                     i_operand_a[`MULDIV_ITER_W-1:0]};
            b_ext = {{(`MULDIV_XLEN-`MULDIV_ITER_W){~i_unsigned & i_operand_b[`MULDIV_ITER_W-1]}},
                     i_operand_b[`MULDIV_ITER_W-1:0]};
        end else begin
            a_ext = i_operand_a;
            b_ext = i_operand_b;
        end

        a_sign = ~i_unsigned & a_ext[`MULDIV_XLEN-1];
        b_sign = ~i_unsigned & b_ext[`MULDIV_XLEN-1];
        a_mag  = a_sign ? -a_ext : a_ext;
        b_mag  = b_sign ? -b_ext : b_ext;

        for (int i = 0; i < `MULDIV_XLEN; i++) begin
            a_flip[i] = a_mag[`MULDIV_XLEN-1-i];
        end
        // Word magnitude sits in the low half, so its MSB must land at bit 0
        a_rev = i_word ? (a_flip >> (`MULDIV_XLEN - `MULDIV_ITER_W)) : a_flip;
    end

    always_comb begin
        iter_d    = iter;
        dvd_d     = dvd >> 1;
        dsr_d     = dsr;
        quo_d     = quo << 1;
        rem_d     = {rem[`MULDIV_XLEN-2:0], dvd[0]};
        quo_neg_d = quo_neg;
        rem_neg_d = rem_neg;
        use_rem_d = use_rem;
        is_word_d = is_word;
        value_d   = o_value;
        valid_d   = 1'b0;

        if (iter == '0) begin
            if (i_valid) begin
                iter_d    = i_word ? iter_t'(`MULDIV_ITER_W) : iter_t'(`MULDIV_ITER_D);
                dvd_d     = a_rev;
                dsr_d     = b_mag;
                quo_d     = '0;
                rem_d     = '0;
                // Divide by zero leaves an all-ones quotient, never negated
                quo_neg_d = (a_sign ^ b_sign) && (b_mag != '0);
                rem_neg_d = a_sign;
                use_rem_d = i_rem;
                is_word_d = i_word;
            end
        end else begin
            iter_d = iter - 1'b1;
            if (rem_d >= dsr) begin
                rem_d    = rem_d - dsr;
                quo_d[0] = 1'b1;
            end

            if (iter_d == '0) begin
                valid_d = 1'b1;
                if (use_rem) begin
                    value_d = rem_neg ? -rem_d : rem_d;
                end else begin
                    value_d = quo_neg ? -quo_d : quo_d;
                end
                if (is_word) begin
                    value_d = {{(`MULDIV_XLEN-`MULDIV_ITER_W){value_d[`MULDIV_ITER_W-1]}},
                               value_d[`MULDIV_ITER_W-1:0]};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            iter    <= '0;
            o_valid <= 1'b0;
        end else begin
            iter    <= iter_d;
            o_valid <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        dvd     <= dvd_d;
        dsr     <= dsr_d;
        quo     <= quo_d;
        rem     <= rem_d;
        quo_neg <= quo_neg_d;
        rem_neg <= rem_neg_d;
        use_rem <= use_rem_d;
        is_word <= is_word_d;
        o_value <= value_d;
    end

endmodule

//--- logic/muldiv_ctrl.sv
`timescale 1ns/1ps

module muldiv_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  muldiv_pkg::muldiv_req_t i_req,
    input  logic                    i_valid,
    input  logic                    i_mul_ready,
    input  logic                    i_mul_valid,
    input  muldiv_pkg::word_t       i_mul_value,
    input  logic                    i_div_ready,
    input  logic                    i_div_valid,
    input  muldiv_pkg::word_t       i_div_value,
    output logic                    o_ready,
    output logic                    o_mul_start,
    output logic [1:0]              o_mul_op,
    output logic                    o_div_start,
    output logic                    o_div_rem,
    output logic                    o_div_unsigned,
    output muldiv_pkg::word_t       o_operand_a,
    output muldiv_pkg::word_t       o_operand_b,
    output logic                    o_word,
    output muldiv_pkg::word_t       o_value,
    output logic                    o_valid
);

    muldiv_pkg::funct3_t op;
    logic                accept;
    logic                to_div;
    // High while the divider owns the operation in flight
    logic                owner_div;

    assign op     = i_req.op;
    assign to_div = op[2];

    assign o_ready = i_mul_ready & i_div_ready;
    assign accept  = i_valid & o_ready;

    assign o_mul_start    = accept & ~to_div;
    assign o_mul_op       = op[1:0];
    assign o_div_start    = accept & to_div;
    assign o_div_rem      = op[1];
    assign o_div_unsigned = op[0];

    assign o_operand_a = i_req.operand_a;
    assign o_operand_b = i_req.operand_b;
    assign o_word      = i_req.is_word;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            owner_div <= 1'b0;
        end else if (accept) begin
            owner_div <= to_div;
        end
    end

    // Result merge
    assign o_value = owner_div ? i_div_value : i_mul_value;
    assign o_valid = owner_div ? i_div_valid : i_mul_valid;

endmodule

//--- logic/muldiv_top.sv
`timescale 1ns/1ps

module muldiv_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  muldiv_pkg::muldiv_req_t i_req,
    input  logic                    i_valid,
    output logic                    o_ready,
    output muldiv_pkg::word_t       o_value,
    output logic                    o_valid
);

    logic              mul_start;
    logic [1:0]        mul_op;
    logic              mul_ready;
    logic              mul_valid;
    muldiv_pkg::word_t mul_value;

    logic              div_start;
    logic              div_rem;
    logic              div_unsigned;
    logic              div_ready;
    logic              div_valid;
    muldiv_pkg::word_t div_value;

    // Shared operand bus to both units
    muldiv_pkg::word_t operand_a;
    muldiv_pkg::word_t operand_b;
    logic              is_word;

    muldiv_ctrl u_muldiv_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_req          (i_req),
        .i_valid        (i_valid),
        .i_mul_ready    (mul_ready),
        .i_mul_valid    (mul_valid),
        .i_mul_value    (mul_value),
        .i_div_ready    (div_ready),
        .i_div_valid    (div_valid),
        .i_div_value    (div_value),
        .o_ready        (o_ready),
        .o_mul_start    (mul_start),
        .o_mul_op       (mul_op),
        .o_div_start    (div_start),
        .o_div_rem      (div_rem),
        .o_div_unsigned (div_unsigned),
        .o_operand_a    (operand_a),
        .o_operand_b    (operand_b),
        .o_word         (is_word),
        .o_value        (o_value),
        .o_valid        (o_valid)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .rstn        (rstn),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_op        (mul_op),
        .i_word      (is_word),
        .i_valid     (mul_start),
        .o_ready     (mul_ready),
        .o_value     (mul_value),
        .o_valid     (mul_valid)
    );

    div_unit u_div_unit (
        .clk         (clk),
        .rstn        (rstn),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_rem       (div_rem),
        .i_unsigned  (div_unsigned),
        .i_word      (is_word),
        .i_valid     (div_start),
        .o_ready     (div_ready),
        .o_value     (div_value),
        .o_valid     (div_valid)
    );

endmodule

//--- sim/muldiv_checker.sv
`timescale 1ns/1ps

module muldiv_checker (
    input  logic                    clk,
    input  logic                    rstn,
    input  muldiv_pkg::muldiv_req_t i_req,
    input  logic                    i_valid,
    input  logic                    i_ready,
    input  muldiv_pkg::word_t       i_value,
    input  logic                    i_result_valid,
    input  logic                    i_report,
    output int                      o_errors,
    output int                      o_pending
);

    typedef struct packed {
        muldiv_pkg::muldiv_req_t req;
        muldiv_pkg::word_t       expected;
        logic [63:0]             due;
    } inflight_t;

    inflight_t   inflight[$];
    inflight_t   entry;
    logic [63:0] cycle = '0;
    int          checked = 0;
    int          reset_edges = 0;
    int          errors = 0;
    int          pending = 0;

    assign o_errors  = errors;
    assign o_pending = pending;

    // RISC-V M-extension result from 128-bit arithmetic
    function automatic muldiv_pkg::word_t reference_result(input muldiv_pkg::muldiv_req_t r);
        muldiv_pkg::word_t   a_s;
        muldiv_pkg::word_t   b_s;
        muldiv_pkg::word_t   a_u;
        muldiv_pkg::word_t   b_u;
        muldiv_pkg::word_t   res;
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic [127:0]        ua;
        logic [127:0]        ub;
        logic [127:0]        wide;
        if (r.is_word) begin
            a_s = {{32{r.operand_a[31]}}, r.operand_a[31:0]};
            b_s = {{32{r.operand_b[31]}}, r.operand_b[31:0]};
            a_u = {32'b0, r.operand_a[31:0]};
            b_u = {32'b0, r.operand_b[31:0]};
        end else begin
            a_s = r.operand_a;
            b_s = r.operand_b;
            a_u = r.operand_a;
            b_u = r.operand_b;
        end
        sa = {{64{a_s[63]}}, a_s};
        sb = {{64{b_s[63]}}, b_s};
        ua = {64'b0, a_u};
        ub = {64'b0, b_u};

        case (r.op)
            3'b000: wide = sa * sb;
            3'b001: wide = (sa * sb) >> 64;
            3'b010: wide = (sa * ub) >> 64;
            3'b011: wide = (ua * ub) >> 64;
            3'b100: begin
                if (ub == '0) wide = '1;
                else          wide = sa / sb;
            end
            3'b101: begin
                if (ub == '0) wide = '1;
                else          wide = ua / ub;
            end
            3'b110: begin
                if (ub == '0) wide = sa;
                else          wide = sa % sb;
            end
            default: begin
                if (ub == '0) wide = ua;
                else          wide = ua % ub;
            end
        endcase

        res = wide[63:0];
        if (r.is_word) begin
            res = {{32{res[31]}}, res[31:0]};
        end
        return res;
    endfunction

    // Edges from acceptance to the registered result
    function automatic int latency_of(input muldiv_pkg::muldiv_req_t r);
        if (r.op[2]) begin
            return r.is_word ? 32 : 64;
        end
        if (r.is_word) begin
            return 3;
        end
        return (r.op == 3'b000) ? 10 : 16;
    endfunction

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rstn) begin
            if (reset_edges > 0 && (i_result_valid !== 1'b0 || i_ready !== 1'b1)) begin
                $display("CHECK FAILED reset state: o_valid %h o_ready %h, expected 0 and 1",
                         i_result_valid, i_ready);
                errors++;
            end
            reset_edges++;
            inflight.delete();
        end else begin
            if (i_result_valid) begin
                // Ready returns together with the result pulse
                if (i_ready !== 1'b1) begin
                    $display("CHECK FAILED o_ready: got %h, expected %h with o_valid",
                             i_ready, 1'b1);
                    errors++;
                end
                if (inflight.size() == 0) begin
                    $display("Result pulse at cycle %0d with no request in flight", cycle);
                    errors++;
                end else begin
                    entry = inflight.pop_front();
                    if (cycle != entry.due) begin
                        $display("Result for op %b word %b came at cycle %0d instead of %0d",
                                 entry.req.op, entry.req.is_word, cycle, entry.due);
                        errors++;
                    end
                    if (i_value !== entry.expected) begin
                        $display("CHECK FAILED o_value: got %h, expected %h (op %b word %b a %h b %h)",
                                 i_value, entry.expected, entry.req.op, entry.req.is_word,
                                 entry.req.operand_a, entry.req.operand_b);
                        errors++;
                    end
                    checked++;
                end
            end else if (inflight.size() != 0) begin
                if (i_ready !== 1'b0) begin
                    $display("CHECK FAILED o_ready: got %h, expected %h while busy", i_ready, 1'b0);
                    errors++;
                end
                if (cycle > inflight[0].due) begin
                    $display("No result for op %b word %b by cycle %0d",
                             inflight[0].req.op, inflight[0].req.is_word, inflight[0].due);
                    errors++;
                    void'(inflight.pop_front());
                end
            end else if (i_ready !== 1'b1) begin
                $display("CHECK FAILED o_ready: got %h, expected %h while idle", i_ready, 1'b1);
                errors++;
            end
            if (i_valid && i_ready) begin
                entry.req      = i_req;
                entry.expected = reference_result(i_req);
                entry.due      = cycle + 64'(latency_of(i_req)) + 64'd1;
                inflight.push_back(entry);
            end
        end
        pending = inflight.size();
    end

    always @(posedge i_report) begin
        $display("muldiv_checker: %0d results checked, %0d still pending, %0d errors",
                 checked, pending, errors);
    end

endmodule

//--- sim/muldiv_tb.sv
`timescale 1ns/1ps

module muldiv_tb;

    localparam int                CYCLES_PER_REQ = 70;
    localparam int                MARGIN_CYCLES  = 200;
    localparam int                NUM_RANDOM     = 400;
    localparam muldiv_pkg::word_t MIN64          = 64'h8000_0000_0000_0000;
    localparam muldiv_pkg::word_t ONES           = 64'hffff_ffff_ffff_ffff;

    logic                    clk;
    logic                    rstn;
    muldiv_pkg::muldiv_req_t req;
    logic                    valid;
    logic                    ready;
    muldiv_pkg::word_t       value;
    logic                    result_valid;
    logic                    report;
    int                      errors;
    int                      pending;
    int                      total_requests;

    muldiv_pkg::muldiv_req_t corners[$];

    muldiv_top u_muldiv_top (
        .clk     (clk),
        .rstn    (rstn),
        .i_req   (req),
        .i_valid (valid),
        .o_ready (ready),
        .o_value (value),
        .o_valid (result_valid)
    );

    muldiv_checker u_muldiv_checker (
        .clk            (clk),
        .rstn           (rstn),
        .i_req          (req),
        .i_valid        (valid),
        .i_ready        (ready),
        .i_value        (value),
        .i_result_valid (result_valid),
        .i_report       (report),
        .o_errors       (errors),
        .o_pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic muldiv_pkg::muldiv_req_t make_req(
        input muldiv_pkg::funct3_t op,
        input logic                is_word,
        input muldiv_pkg::word_t   a,
        input muldiv_pkg::word_t   b
    );
        muldiv_pkg::muldiv_req_t r;
        r.op        = op;
        r.is_word   = is_word;
        r.operand_a = a;
        r.operand_b = b;
        return r;
    endfunction

    task automatic add_corner(input logic [2:0] op, input logic w,
                              input muldiv_pkg::word_t a, input muldiv_pkg::word_t b);
        corners.push_back(make_req(op, w, a, b));
    endtask

    task automatic load_corner_cases();
        // Low product, negative operands, word sign extension
        add_corner(3'b000, 1'b0, 64'd3, 64'd5);
        add_corner(3'b000, 1'b0, -64'd7, 64'd9);
        add_corner(3'b000, 1'b0, 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210);
        add_corner(3'b000, 1'b1, 64'h7fff_ffff, 64'd2);
        add_corner(3'b000, 1'b1, 64'hdead_beef_ffff_fffd, 64'h1234_5678_0000_0005);
        // High product with extreme operands
        add_corner(3'b001, 1'b0, ONES, ONES);
        add_corner(3'b001, 1'b0, MIN64, MIN64);
        add_corner(3'b001, 1'b0, MIN64, ONES);
        add_corner(3'b010, 1'b0, ONES, ONES);
        add_corner(3'b010, 1'b0, MIN64, ONES);
        add_corner(3'b011, 1'b0, ONES, ONES);
        add_corner(3'b011, 1'b0, MIN64, 64'd2);
        // Truncation toward zero
        add_corner(3'b100, 1'b0, -64'd7, 64'd2);
        add_corner(3'b110, 1'b0, -64'd7, 64'd2);
        add_corner(3'b100, 1'b0, 64'd7, -64'd2);
        add_corner(3'b110, 1'b0, 64'd7, -64'd2);
        add_corner(3'b101, 1'b0, -64'd7, 64'd2);
        add_corner(3'b111, 1'b0, -64'd7, 64'd2);
        add_corner(3'b100, 1'b1, 64'hffff_0000_ffff_fff9, 64'd2);
        add_corner(3'b110, 1'b1, 64'hffff_0000_ffff_fff9, 64'd2);
        add_corner(3'b101, 1'b1, 64'h0000_0001_ffff_fff9, 64'd2);
        add_corner(3'b111, 1'b1, 64'h0000_0001_ffff_fff9, 64'd2);
        // Zero divisor, the word one has high bits set
        for (int op = 4; op < 8; op++) begin
            add_corner(3'(op), 1'b0, -64'd5, 64'd0);
            add_corner(3'(op), 1'b1, 64'h1234_5678_8000_0003, 64'h5555_5555_0000_0000);
        end
        // Signed overflow
        add_corner(3'b100, 1'b0, MIN64, ONES);
        add_corner(3'b110, 1'b0, MIN64, ONES);
        add_corner(3'b100, 1'b1, 64'h8000_0000, ONES);
        add_corner(3'b110, 1'b1, 64'h8000_0000, ONES);
    endtask

    function automatic muldiv_pkg::word_t random_operand();
        muldiv_pkg::word_t v;
        case ($urandom_range(0, 7))
            0:       v = '0;
            1:       v = 64'd1;
            2:       v = ONES;
            3:       v = MIN64;
            4:       v = 64'($urandom_range(0, 255));
            5:       v = {$urandom, 32'h8000_0000};
            default: v = {$urandom, $urandom};
        endcase
        return v;
    endfunction

    // Thirteen operations, MULH family only in doubleword form
    function automatic muldiv_pkg::muldiv_req_t random_request();
        int                pick;
        muldiv_pkg::word_t a;
        muldiv_pkg::word_t b;
        pick = $urandom_range(0, 12);
        a    = random_operand();
        b    = random_operand();
        if (pick < 8) begin
            return make_req(3'(pick), 1'b0, a, b);
        end
        return make_req((pick == 8) ? 3'b000 : 3'(pick - 5), 1'b1, a, b);
    endfunction

    // Called on a rising edge, returns on the accepting edge
    task automatic send_request(input muldiv_pkg::muldiv_req_t r);
        req   <= r;
        valid <= 1'b1;
        @(posedge clk);
        while (!ready) begin
            @(posedge clk);
        end
        valid <= 1'b0;
    endtask

    // Offers a second request while the divider is busy
    task automatic probe_while_busy();
        send_request(make_req(3'b100, 1'b0, 64'd1000, 64'd7));
        req   <= make_req(3'b000, 1'b0, 64'd11, 64'd13);
        valid <= 1'b1;
        repeat (6) @(posedge clk);
        valid <= 1'b0;
    endtask

    initial begin
        int gap;
        void'($urandom(32'hcfe8e9b8));
        rstn           = 1'b0;
        valid          = 1'b0;
        req            = '0;
        report         = 1'b0;
        total_requests = 0;
        load_corner_cases();
        total_requests = corners.size() + NUM_RANDOM + 2;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        foreach (corners[i]) begin
            send_request(corners[i]);
        end
        probe_while_busy();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_request(random_request());
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge clk);
        end

        @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        report = 1'b1;
        #1;
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (total_requests != 0);
        repeat (total_requests * CYCLES_PER_REQ + MARGIN_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles",
                 total_requests * CYCLES_PER_REQ + MARGIN_CYCLES);
        report = 1'b1;
        #1;
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/muldiv_pkg.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
logic/muldiv_ctrl.sv
logic/muldiv_top.sv
sim/muldiv_checker.sv
sim/muldiv_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module muldiv_tb -o muldiv_sim \
    && ./obj_dir/muldiv_sim > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
